//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_sigma_tile -Mdir obj_dir -f src.f || exit 1
out=$(./obj_dir/Vtb_sigma_tile)
echo "$out"
echo "$out" | grep -q "^Simulation finished: PASS$" && exit 0 || exit 1

//--- sim/tb_sigma_tile.sv
`default_nettype none

module tb_sigma_tile;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MEM_SIZE = 256;
    localparam int CORENUM = 5;
    localparam bit CPU_RESET_DEFAULT = 1'b1;
    localparam logic [31:0] SEED = 32'h85fd_eb88;
    localparam logic [31:0] XBUS_KEY = 32'h5eed_c0de;
    localparam logic [31:0] SFR_BASE = 32'h1 << tile_pkg::SFR_BITSEL;
    localparam logic [31:0] XBUS_BASE = 32'h1 << tile_pkg::XBUS_BITSEL;
    localparam int N_RAM = 16;
    localparam int N_DUAL = 4;
    localparam int N_XBUS = 20;
    localparam int TOTAL_TRANS = 3 * N_RAM + 4 * N_DUAL + N_XBUS + 24;
    localparam int WAIT_LIMIT = 50;

    logic clk_i;
    logic reset_i;
    logic irq_debounced_i;
    logic host_req_i;
    logic host_we_i;
    logic [tile_pkg::ADDR_W-1:0] host_addr_i;
    logic [tile_pkg::BE_W-1:0] host_be_i;
    logic [tile_pkg::DATA_W-1:0] host_wdata_i;
    logic host_ack_o;
    logic host_resp_o;
    logic [tile_pkg::DATA_W-1:0] host_rdata_o;
    logic cpu_req_i;
    logic cpu_we_i;
    logic [tile_pkg::ADDR_W-1:0] cpu_addr_i;
    logic [tile_pkg::BE_W-1:0] cpu_be_i;
    logic [tile_pkg::DATA_W-1:0] cpu_wdata_i;
    logic cpu_ack_o;
    logic cpu_resp_o;
    logic [tile_pkg::DATA_W-1:0] cpu_rdata_o;
    logic xbus_req_o;
    logic xbus_we_o;
    logic [tile_pkg::ADDR_W-1:0] xbus_addr_o;
    logic [tile_pkg::BE_W-1:0] xbus_be_o;
    logic [tile_pkg::DATA_W-1:0] xbus_wdata_o;
    logic xbus_ack_i;
    logic xbus_resp_i;
    logic [tile_pkg::DATA_W-1:0] xbus_rdata_i;
    logic cpu_reset_o;
    logic irq_req_o;
    logic [tile_pkg::IRQ_CODE_W-1:0] irq_code_o;
    logic irq_ack_i;

    // reference state
    logic [31:0] ram_model [int];
    logic ref_reset = CPU_RESET_DEFAULT;
    logic [31:0] host_expect [$];
    logic [31:0] cpu_expect [$];
    logic [31:0] stim_rng = SEED;
    logic [31:0] xbus_rng = SEED ^ 32'h5a5a_5a5a;
    logic [31:0] ram_addrs [N_RAM];
    int cycle_count = 0;
    int host_acc_cycle = 0;
    int cpu_acc_cycle = 0;
    string test_name = "reset";

    sigma_tile
    #(
        .MEM_SIZE(MEM_SIZE)
        , .CORENUM(CORENUM)
        , .CPU_RESET_DEFAULT(CPU_RESET_DEFAULT)
        , .XBUS_BITSEL(tile_pkg::XBUS_BITSEL)
        , .SFR_BITSEL(tile_pkg::SFR_BITSEL)
    ) UUT (
        .clk_i(clk_i)
        , .reset_i(reset_i)
        , .irq_debounced_i(irq_debounced_i)
        , .host_req_i(host_req_i)
        , .host_we_i(host_we_i)
        , .host_addr_i(host_addr_i)
        , .host_be_i(host_be_i)
        , .host_wdata_i(host_wdata_i)
        , .host_ack_o(host_ack_o)
        , .host_resp_o(host_resp_o)
        , .host_rdata_o(host_rdata_o)
        , .cpu_req_i(cpu_req_i)
        , .cpu_we_i(cpu_we_i)
        , .cpu_addr_i(cpu_addr_i)
        , .cpu_be_i(cpu_be_i)
        , .cpu_wdata_i(cpu_wdata_i)
        , .cpu_ack_o(cpu_ack_o)
        , .cpu_resp_o(cpu_resp_o)
        , .cpu_rdata_o(cpu_rdata_o)
        , .xbus_req_o(xbus_req_o)
        , .xbus_we_o(xbus_we_o)
        , .xbus_addr_o(xbus_addr_o)
        , .xbus_be_o(xbus_be_o)
        , .xbus_wdata_o(xbus_wdata_o)
        , .xbus_ack_i(xbus_ack_i)
        , .xbus_resp_i(xbus_resp_i)
        , .xbus_rdata_i(xbus_rdata_i)
        , .cpu_reset_o(cpu_reset_o)
        , .irq_req_o(irq_req_o)
        , .irq_code_o(irq_code_o)
        , .irq_ack_i(irq_ack_i)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] r;
        r = x ^ (x << 13);
        r = r ^ (r >> 17);
        r = r ^ (r << 5);
        return r;
    endfunction

    function automatic logic [31:0] rand32();
        stim_rng = xorshift(stim_rng);
        return stim_rng;
    endfunction

    // what the expansion bus answers for an address
    function automatic logic [31:0] xbus_value(input logic [31:0] addr);
        return addr ^ XBUS_KEY;
    endfunction

    function automatic int word_index(input logic [31:0] addr);
        return int'((addr >> 2) % 32'(MEM_SIZE));
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
        input logic [31:0] new_word, input logic [3:0] be);
        logic [31:0] r;
        r = old_word;
        for (int b = 0; b < 4; b++)
        begin
            if (be[b])
                r[b*8 +: 8] = new_word[b*8 +: 8];
        end
        return r;
    endfunction

    function automatic logic [31:0] expected_read(input logic [31:0] addr);
        logic [31:0] r;
        if (addr[tile_pkg::XBUS_BITSEL])
            r = xbus_value(addr);
        else if (addr[tile_pkg::SFR_BITSEL])
        begin
            case (addr[3:0])
                4'(tile_pkg::SFR_COREID_OFS): r = 32'(CORENUM);
                4'(tile_pkg::SFR_RESET_OFS): r = 32'(ref_reset);
                default: r = '0;
            endcase
        end
        else
            r = ram_model[word_index(addr)];
        return r;
    endfunction

    // external line wins over a pending message
    function automatic logic [7:0] expected_irq_code(input bit ext_pending,
        input logic [7:0] msg_code);
        return ext_pending ? tile_pkg::IRQ_EXT_CODE : msg_code;
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_value(input string name, input logic [31:0] expected,
        input logic [31:0] actual);
        if (actual !== expected)
            fail_run($sformatf("mismatch %s: expected %h, actual %h", name, expected, actual));
    endtask

    task automatic record_accept(input bit from_cpu, input logic we, input logic [31:0] addr,
        input logic [3:0] be, input logic [31:0] wdata);
        int idx;
        logic [31:0] old_word;
        if (from_cpu)
            cpu_acc_cycle = cycle_count;
        else
            host_acc_cycle = cycle_count;
        if (addr[tile_pkg::XBUS_BITSEL])
        begin
            compare_value({test_name, " xbus_addr_o"}, addr, xbus_addr_o);
            compare_value({test_name, " xbus_we_o"}, 32'(we), 32'(xbus_we_o));
            compare_value({test_name, " xbus_be_o"}, 32'(be), 32'(xbus_be_o));
            if (we)
                compare_value({test_name, " xbus_wdata_o"}, wdata, xbus_wdata_o);
        end
        if (!we)
        begin
            if (from_cpu)
                cpu_expect.push_back(expected_read(addr));
            else
                host_expect.push_back(expected_read(addr));
        end
        else if (!addr[tile_pkg::XBUS_BITSEL] && addr[tile_pkg::SFR_BITSEL])
        begin
            if (addr[3:0] == 4'(tile_pkg::SFR_RESET_OFS))
                ref_reset = wdata[0];
        end
        else if (!addr[tile_pkg::XBUS_BITSEL])
        begin
            idx = word_index(addr);
            old_word = ram_model.exists(idx) ? ram_model[idx] : '0;
            ram_model[idx] = merge_bytes(old_word, wdata, be);
        end
    endtask

    // one request from one master, held until acknowledged
    task automatic bus_access(input bit use_cpu, input bit we, input logic [31:0] addr,
        input logic [3:0] be, input logic [31:0] wdata);
        @(negedge clk_i);
        if (use_cpu)
        begin
            cpu_req_i = 1'b1;
            cpu_we_i = we;
            cpu_addr_i = addr;
            cpu_be_i = be;
            cpu_wdata_i = wdata;
        end
        else
        begin
            host_req_i = 1'b1;
            host_we_i = we;
            host_addr_i = addr;
            host_be_i = be;
            host_wdata_i = wdata;
        end
        do
            @(posedge clk_i);
        while (!(use_cpu ? cpu_ack_o : host_ack_o));
        @(negedge clk_i);
        if (use_cpu)
            cpu_req_i = 1'b0;
        else
            host_req_i = 1'b0;
    endtask

    task automatic serve_irq(input string name, input logic [7:0] code);
        int waited;
        waited = 0;
        @(posedge clk_i);
        while (!irq_req_o)
        begin
            waited++;
            if (waited > WAIT_LIMIT)
                fail_run("interrupt request was never raised");
            @(posedge clk_i);
        end
        compare_value(name, 32'(code), 32'(irq_code_o));
        @(negedge clk_i);
        irq_ack_i = 1'b1;
        @(negedge clk_i);
        irq_ack_i = 1'b0;
    endtask

    // compare process, pops expectations on resp and records acceptances
    always @(posedge clk_i)
    begin
        if (!reset_i)
        begin
            cycle_count++;
            compare_value({test_name, " cpu_reset_o"}, 32'(ref_reset), 32'(cpu_reset_o));
            if (host_resp_o)
            begin
                if (host_expect.size() == 0)
                    fail_run("host got a read response with no read outstanding");
                compare_value({test_name, " host read"}, host_expect.pop_front(), host_rdata_o);
            end
            if (cpu_resp_o)
            begin
                if (cpu_expect.size() == 0)
                    fail_run("cpu got a read response with no read outstanding");
                compare_value({test_name, " cpu read"}, cpu_expect.pop_front(), cpu_rdata_o);
            end
            if (host_ack_o)
                record_accept(1'b0, host_we_i, host_addr_i, host_be_i, host_wdata_i);
            if (cpu_ack_o)
                record_accept(1'b1, cpu_we_i, cpu_addr_i, cpu_be_i, cpu_wdata_i);
        end
    end

    initial
    begin : xbus_responder
        logic seen_req;
        logic accepted;
        logic acc_read;
        logic [31:0] acc_addr;
        logic [31:0] rd_addr;
        bit rd_open;
        int ack_wait;
        int resp_wait;

        xbus_ack_i = 1'b0;
        xbus_resp_i = 1'b0;
        xbus_rdata_i = '0;
        rd_open = 1'b0;
        rd_addr = '0;
        ack_wait = 0;
        resp_wait = 0;
        forever
        begin
            @(posedge clk_i);
            seen_req = xbus_req_o;
            accepted = xbus_req_o && xbus_ack_i;
            acc_read = accepted && !xbus_we_o;
            acc_addr = xbus_addr_o;
            @(negedge clk_i);
            xbus_resp_i = 1'b0;
            if (accepted)
            begin
                xbus_ack_i = 1'b0;
                xbus_rng = xorshift(xbus_rng);
                ack_wait = int'(xbus_rng[1:0]);
            end
            else if (seen_req && !xbus_ack_i)
            begin
                if (ack_wait == 0)
                    xbus_ack_i = 1'b1;
                else
                    ack_wait--;
            end
            if (acc_read)
            begin
                rd_open = 1'b1;
                rd_addr = acc_addr;
                xbus_rng = xorshift(xbus_rng);
                resp_wait = int'(xbus_rng[4:2]);
            end
            if (rd_open)
            begin
                if (resp_wait == 0)
                begin
                    xbus_resp_i = 1'b1;
                    xbus_rdata_i = xbus_value(rd_addr);
                    rd_open = 1'b0;
                end
                else
                    resp_wait--;
            end
        end
    end

    initial
    begin : watchdog
        repeat (TOTAL_TRANS * 40) @(posedge clk_i);
        fail_run("watchdog expired before the tests finished");
    end

    initial
    begin : main_sequence
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        int waited;

        reset_i = 1'b1;
        irq_debounced_i = 1'b0;
        irq_ack_i = 1'b0;
        host_req_i = 1'b0;
        host_we_i = 1'b0;
        host_addr_i = '0;
        host_be_i = '0;
        host_wdata_i = '0;
        cpu_req_i = 1'b0;
        cpu_we_i = 1'b0;
        cpu_addr_i = '0;
        cpu_be_i = '0;
        cpu_wdata_i = '0;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;

        @(posedge clk_i);
        compare_value("reset idle outputs", 32'h0, 32'({host_ack_o, cpu_ack_o, host_resp_o,
            cpu_resp_o, xbus_req_o, irq_req_o}));
        compare_value("reset cpu_reset_o", 32'(CPU_RESET_DEFAULT), 32'(cpu_reset_o));

        // full words first so partial writes merge into known data
        test_name = "ram";
        for (int i = 0; i < N_RAM; i++)
        begin
            ram_addrs[i] = rand32() & 32'h0000_0ffc;
            bus_access(1'b0, 1'b1, ram_addrs[i], 4'hf, rand32());
        end
        for (int i = 0; i < N_RAM; i++)
        begin
            r = rand32();
            a = ram_addrs[int'(r[7:0] % 8'(N_RAM))];
            bus_access(1'b0, 1'b1, a, r[11:8], rand32());
        end
        for (int i = 0; i < N_RAM; i++)
            bus_access(1'b0, 1'b0, ram_addrs[i], 4'hf, 32'h0);

        test_name = "dual";
        for (int i = 0; i < N_DUAL; i++)
        begin
            a = rand32() & 32'h0000_0ffc;
            b = a ^ 32'h0000_0004;
            bus_access(1'b1, 1'b1, a, 4'hf, rand32());
            bus_access(1'b0, 1'b1, b, 4'hf, rand32());
            fork
                bus_access(1'b0, 1'b0, a, 4'hf, 32'h0);
                bus_access(1'b1, 1'b0, b, 4'hf, 32'h0);
            join
            compare_value("dual host first", 32'h1, 32'(host_acc_cycle < cpu_acc_cycle));
        end

        test_name = "sfr";
        bus_access(1'b0, 1'b0, SFR_BASE | 32'(tile_pkg::SFR_COREID_OFS), 4'hf, 32'h0);
        bus_access(1'b1, 1'b0, SFR_BASE | 32'(tile_pkg::SFR_RESET_OFS), 4'hf, 32'h0);
        bus_access(1'b0, 1'b1, SFR_BASE | 32'(tile_pkg::SFR_RESET_OFS), 4'hf, 32'hffff_fffe);
        bus_access(1'b1, 1'b0, SFR_BASE | 32'(tile_pkg::SFR_RESET_OFS), 4'hf, 32'h0);
        bus_access(1'b1, 1'b1, SFR_BASE | 32'(tile_pkg::SFR_RESET_OFS), 4'hf, 32'h0000_0001);
        bus_access(1'b0, 1'b0, SFR_BASE | 32'(tile_pkg::SFR_RESET_OFS), 4'hf, 32'h0);
        bus_access(1'b0, 1'b0, SFR_BASE | 32'h0000_000c, 4'hf, 32'h0);

        test_name = "irq";
        bus_access(1'b1, 1'b1, SFR_BASE | 32'(tile_pkg::SFR_MSI_OFS), 4'hf, 32'h0000_003c);
        serve_irq("irq message code", expected_irq_code(1'b0, 8'h3c));
        @(posedge clk_i);
        compare_value("irq cleared by ack", 32'h0, 32'(irq_req_o));
        // edge lands in the same cycle as the message strobe
        bus_access(1'b0, 1'b1, SFR_BASE | 32'(tile_pkg::SFR_MSI_OFS), 4'hf, 32'h0000_00a5);
        irq_debounced_i = 1'b1;
        serve_irq("irq external first", expected_irq_code(1'b1, 8'ha5));
        serve_irq("irq message after external", expected_irq_code(1'b0, 8'ha5));
        irq_debounced_i = 1'b0;
        @(posedge clk_i);
        compare_value("irq idle after both", 32'h0, 32'(irq_req_o));

        test_name = "xbus";
        for (int i = 0; i < N_XBUS; i++)
        begin
            a = XBUS_BASE | (rand32() & 32'h7fff_fffc);
            r = rand32();
            bus_access(r[0], r[1], a, r[7:4], rand32());
        end
        fork
            bus_access(1'b0, 1'b0, XBUS_BASE | 32'h0010_0040, 4'hf, 32'h0);
            bus_access(1'b1, 1'b0, ram_addrs[0], 4'hf, 32'h0);
        join
        fork
            bus_access(1'b0, 1'b0, ram_addrs[1], 4'hf, 32'h0);
            bus_access(1'b1, 1'b0, XBUS_BASE | 32'h0000_1230, 4'hf, 32'h0);
        join

        test_name = "drain";
        waited = 0;
        while ((host_expect.size() != 0 || cpu_expect.size() != 0) && waited < WAIT_LIMIT)
        begin
            @(posedge clk_i);
            waited++;
        end
        if (host_expect.size() == 0 && cpu_expect.size() == 0)
        begin
            $display("Simulation finished: PASS");
            $finish;
        end
        else
            fail_run("read responses still missing at the end of the run");
    end

endmodule

`default_nettype wire

//--- src.f
verilog/tile_pkg.sv
verilog/bus_arbiter.sv
verilog/data_ram.sv
verilog/sfr_block.sv
verilog/irq_adapter.sv
verilog/sigma_tile.sv
sim/tb_sigma_tile.sv

//--- verilog/bus_arbiter.sv
`default_nettype none

module bus_arbiter
#(
    parameter int XBUS_BITSEL = tile_pkg::XBUS_BITSEL
    , parameter int SFR_BITSEL = tile_pkg::SFR_BITSEL
)
(
    input logic clk_i
    , input logic reset_i

    , input logic host_req_i
    , input logic host_we_i
    , input logic [tile_pkg::ADDR_W-1:0] host_addr_i
    , input logic [tile_pkg::BE_W-1:0] host_be_i
    , input logic [tile_pkg::DATA_W-1:0] host_wdata_i
    , output logic host_ack_o
    , output logic host_resp_o
    , output logic [tile_pkg::DATA_W-1:0] host_rdata_o

    , input logic cpu_req_i
    , input logic cpu_we_i
    , input logic [tile_pkg::ADDR_W-1:0] cpu_addr_i
    , input logic [tile_pkg::BE_W-1:0] cpu_be_i
    , input logic [tile_pkg::DATA_W-1:0] cpu_wdata_i
    , output logic cpu_ack_o
    , output logic cpu_resp_o
    , output logic [tile_pkg::DATA_W-1:0] cpu_rdata_o

    , output logic ram_req_o
    , output logic ram_we_o
    , output logic [tile_pkg::ADDR_W-1:0] ram_addr_o
    , output logic [tile_pkg::BE_W-1:0] ram_be_o
    , output logic [tile_pkg::DATA_W-1:0] ram_wdata_o
    , input logic ram_ack_i
    , input logic ram_resp_i
    , input logic [tile_pkg::DATA_W-1:0] ram_rdata_i

    , output logic sfr_req_o
    , output logic sfr_we_o
    , output logic [tile_pkg::ADDR_W-1:0] sfr_addr_o
    , output logic [tile_pkg::BE_W-1:0] sfr_be_o
    , output logic [tile_pkg::DATA_W-1:0] sfr_wdata_o
    , input logic sfr_ack_i
    , input logic sfr_resp_i
    , input logic [tile_pkg::DATA_W-1:0] sfr_rdata_i

    , output logic xbus_req_o
    , output logic xbus_we_o
    , output logic [tile_pkg::ADDR_W-1:0] xbus_addr_o
    , output logic [tile_pkg::BE_W-1:0] xbus_be_o
    , output logic [tile_pkg::DATA_W-1:0] xbus_wdata_o
    , input logic xbus_ack_i
    , input logic xbus_resp_i
    , input logic [tile_pkg::DATA_W-1:0] xbus_rdata_i
);

    logic host_sel;
    logic m_req;
    logic m_we;
    logic [tile_pkg::ADDR_W-1:0] m_addr;
    logic [tile_pkg::BE_W-1:0] m_be;
    logic [tile_pkg::DATA_W-1:0] m_wdata;

    logic sel_xbus;
    logic sel_sfr;
    logic sel_ram;
    logic tgt_ack;
    logic tgt_resp;
    logic [tile_pkg::DATA_W-1:0] tgt_rdata;

    logic rd_pending;
    logic rd_from_cpu;
    logic rd_block;
    logic accept;

    // fixed priority, host first
    assign host_sel = host_req_i;
    assign m_we     = host_sel ? host_we_i    : cpu_we_i;
    assign m_addr   = host_sel ? host_addr_i  : cpu_addr_i;
    assign m_be     = host_sel ? host_be_i    : cpu_be_i;
    assign m_wdata  = host_sel ? host_wdata_i : cpu_wdata_i;

    // a read finishing this cycle frees the bus for the next request
    assign tgt_resp = ram_resp_i || sfr_resp_i || xbus_resp_i;
    assign rd_block = rd_pending && !tgt_resp;
    assign m_req    = (host_req_i || cpu_req_i) && !rd_block;

    assign sel_xbus = m_addr[XBUS_BITSEL];
    assign sel_sfr  = !sel_xbus && m_addr[SFR_BITSEL];
    assign sel_ram  = !sel_xbus && !sel_sfr;

    assign ram_req_o    = m_req && sel_ram;
    assign ram_we_o     = m_we;
    assign ram_addr_o   = m_addr;
    assign ram_be_o     = m_be;
    assign ram_wdata_o  = m_wdata;

    assign sfr_req_o    = m_req && sel_sfr;
    assign sfr_we_o     = m_we;
    assign sfr_addr_o   = m_addr;
    assign sfr_be_o     = m_be;
    assign sfr_wdata_o  = m_wdata;

    assign xbus_req_o   = m_req && sel_xbus;
    assign xbus_we_o    = m_we;
    assign xbus_addr_o  = m_addr;
    assign xbus_be_o    = m_be;
    assign xbus_wdata_o = m_wdata;

    assign tgt_ack = sel_xbus ? xbus_ack_i : (sel_sfr ? sfr_ack_i : ram_ack_i);
    assign accept  = m_req && tgt_ack;

    assign host_ack_o = accept && host_sel;
    assign cpu_ack_o  = accept && !host_sel;

    assign tgt_rdata = ram_resp_i ? ram_rdata_i : (sfr_resp_i ? sfr_rdata_i : xbus_rdata_i);

    // response goes back to whoever issued the read
    assign host_resp_o  = tgt_resp && rd_pending && !rd_from_cpu;
    assign cpu_resp_o   = tgt_resp && rd_pending && rd_from_cpu;
    assign host_rdata_o = tgt_rdata;
    assign cpu_rdata_o  = tgt_rdata;

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            rd_pending  <= 1'b0;
            rd_from_cpu <= 1'b0;
        end
        else if (accept && !m_we)
        begin
            rd_pending  <= 1'b1;
            rd_from_cpu <= !host_sel;
        end
        else if (tgt_resp)
        begin
            rd_pending <= 1'b0;
        end
    end

    // targets answer only reads this arbiter let through
    assert property (@(posedge clk_i) disable iff (reset_i) tgt_resp |-> rd_pending)
        else $error("target response with no read outstanding");

    // one read in flight means one answering target at a time
    assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0({ram_resp_i, sfr_resp_i, xbus_resp_i}))
        else $error("several targets responded in one cycle");

endmodule

`default_nettype wire

//--- verilog/data_ram.sv
`default_nettype none

module data_ram
#(
    parameter int MEM_SIZE = 1024
)
(
    input logic clk_i
    , input logic reset_i

    , input logic req_i
    , input logic we_i
    , input logic [tile_pkg::ADDR_W-1:0] addr_i
    , input logic [tile_pkg::BE_W-1:0] be_i
    , input logic [tile_pkg::DATA_W-1:0] wdata_i
    , output logic ack_o
    , output logic resp_o
    , output logic [tile_pkg::DATA_W-1:0] rdata_o
);

    localparam int IDX_W = (MEM_SIZE > 1) ? $clog2(MEM_SIZE) : 1;

    logic [tile_pkg::DATA_W-1:0] mem [MEM_SIZE];
    logic [tile_pkg::ADDR_W-3:0] word_addr;
    logic [IDX_W-1:0] idx;

    // word address wraps over the memory depth
    assign word_addr = addr_i[tile_pkg::ADDR_W-1:2];
    assign idx       = IDX_W'(word_addr % MEM_SIZE);

    assign ack_o = 1'b1;

    always_ff @(posedge clk_i)
    begin
        if (req_i && we_i)
        begin
            for (int b = 0; b < tile_pkg::BE_W; b++)
            begin
                if (be_i[b])
                    mem[idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
            end
        end
        if (req_i && !we_i)
            rdata_o <= mem[idx];
    end

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
            resp_o <= 1'b0;
        else
            resp_o <= req_i && !we_i;
    end

endmodule

`default_nettype wire

//--- verilog/irq_adapter.sv
`default_nettype none

module irq_adapter
(
    input logic clk_i
    , input logic reset_i

    , input logic irq_debounced_i
    , input logic msi_req_i
    , input logic [tile_pkg::IRQ_CODE_W-1:0] msi_code_i

    , output logic irq_req_o
    , output logic [tile_pkg::IRQ_CODE_W-1:0] irq_code_o
    , input logic irq_ack_i
);

    logic irq_prev;
    logic ext_edge;
    logic ext_pend;
    logic msi_pend;
    logic cur_ext;
    logic [tile_pkg::IRQ_CODE_W-1:0] msi_code_q;

    logic ack_fire;
    logic ext_clr;
    logic msi_clr;
    logic msi_load;
    logic ext_pend_n;
    logic msi_pend_n;
    logic [tile_pkg::IRQ_CODE_W-1:0] msi_code_n;
    logic present;

    assign ext_edge = irq_debounced_i && !irq_prev;
    assign ack_fire = irq_req_o && irq_ack_i;
    assign ext_clr  = ack_fire && cur_ext;
    assign msi_clr  = ack_fire && !cur_ext;

    // a second message is lost while the first still waits
    assign msi_load   = msi_req_i && (!msi_pend || msi_clr);
    assign ext_pend_n = ext_edge || (ext_pend && !ext_clr);
    assign msi_pend_n = msi_load || (msi_pend && !msi_clr);
    assign msi_code_n = msi_load ? msi_code_i : msi_code_q;

    // presented source is held until acked, a later edge waits its turn
    assign present = !irq_req_o || ack_fire;

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            irq_prev  <= 1'b0;
            ext_pend  <= 1'b0;
            msi_pend  <= 1'b0;
            irq_req_o <= 1'b0;
            cur_ext   <= 1'b0;
        end
        else
        begin
            irq_prev <= irq_debounced_i;
            ext_pend <= ext_pend_n;
            msi_pend <= msi_pend_n;
            if (present)
            begin
                irq_req_o <= ext_pend_n || msi_pend_n;
                cur_ext   <= ext_pend_n;
            end
        end
    end

    always_ff @(posedge clk_i)
    begin
        msi_code_q <= msi_code_n;
        if (present)
            irq_code_o <= ext_pend_n ? tile_pkg::IRQ_EXT_CODE : msi_code_n;
    end

    // any new source shows up as a request in the next cycle
    assert property (@(posedge clk_i) disable iff (reset_i)
        ext_edge || msi_req_i |=> irq_req_o)
        else $error("interrupt source did not raise the request");

endmodule

`default_nettype wire

//--- verilog/sfr_block.sv
`default_nettype none

module sfr_block
#(
    parameter int CORENUM = 0
    , parameter bit CPU_RESET_DEFAULT = 1'b0
)
(
    input logic clk_i
    , input logic reset_i

    , input logic req_i
    , input logic we_i
    , input logic [tile_pkg::ADDR_W-1:0] addr_i
    , input logic [tile_pkg::BE_W-1:0] be_i
    , input logic [tile_pkg::DATA_W-1:0] wdata_i
    , output logic ack_o
    , output logic resp_o
    , output logic [tile_pkg::DATA_W-1:0] rdata_o

    , output logic cpu_reset_o
    , output logic msi_req_o
    , output logic [tile_pkg::IRQ_CODE_W-1:0] msi_code_o
);

    localparam int OFS_W = 4;
    localparam logic [OFS_W-1:0] COREID_OFS = OFS_W'(tile_pkg::SFR_COREID_OFS);
    localparam logic [OFS_W-1:0] RESET_OFS  = OFS_W'(tile_pkg::SFR_RESET_OFS);
    localparam logic [OFS_W-1:0] MSI_OFS    = OFS_W'(tile_pkg::SFR_MSI_OFS);

    logic [OFS_W-1:0] ofs;
    logic wr_low;
    logic wr_reset;
    logic wr_msi;

    assign ofs = addr_i[OFS_W-1:0];

    // both writable registers live in byte 0
    assign wr_low   = req_i && we_i && be_i[0];
    assign wr_reset = wr_low && (ofs == RESET_OFS);
    assign wr_msi   = wr_low && (ofs == MSI_OFS);

    assign ack_o = 1'b1;

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            resp_o      <= 1'b0;
            msi_req_o   <= 1'b0;
            cpu_reset_o <= CPU_RESET_DEFAULT;
        end
        else
        begin
            resp_o    <= req_i && !we_i;
            msi_req_o <= wr_msi;
            if (wr_reset)
                cpu_reset_o <= wdata_i[0];
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (req_i && !we_i)
        begin
            case (ofs)
                COREID_OFS: rdata_o <= tile_pkg::DATA_W'(CORENUM);
                RESET_OFS:  rdata_o <= tile_pkg::DATA_W'(cpu_reset_o);
                default:    rdata_o <= '0;
            endcase
        end
        // message trigger carries its code in the low byte
        if (wr_msi)
            msi_code_o <= wdata_i[tile_pkg::IRQ_CODE_W-1:0];
    end

endmodule

`default_nettype wire

//--- verilog/sigma_tile.sv
`default_nettype none

module sigma_tile
#(
    parameter int MEM_SIZE = 1024
    , parameter int CORENUM = 0
    , parameter bit CPU_RESET_DEFAULT = 1'b0
    , parameter int XBUS_BITSEL = tile_pkg::XBUS_BITSEL
    , parameter int SFR_BITSEL = tile_pkg::SFR_BITSEL
)
(
    input logic clk_i
    , input logic reset_i
    , input logic irq_debounced_i

    // host port
    , input logic host_req_i
    , input logic host_we_i
    , input logic [tile_pkg::ADDR_W-1:0] host_addr_i
    , input logic [tile_pkg::BE_W-1:0] host_be_i
    , input logic [tile_pkg::DATA_W-1:0] host_wdata_i
    , output logic host_ack_o
    , output logic host_resp_o
    , output logic [tile_pkg::DATA_W-1:0] host_rdata_o

    // core data port
    , input logic cpu_req_i
    , input logic cpu_we_i
    , input logic [tile_pkg::ADDR_W-1:0] cpu_addr_i
    , input logic [tile_pkg::BE_W-1:0] cpu_be_i
    , input logic [tile_pkg::DATA_W-1:0] cpu_wdata_i
    , output logic cpu_ack_o
    , output logic cpu_resp_o
    , output logic [tile_pkg::DATA_W-1:0] cpu_rdata_o

    // expansion bus
    , output logic xbus_req_o
    , output logic xbus_we_o
    , output logic [tile_pkg::ADDR_W-1:0] xbus_addr_o
    , output logic [tile_pkg::BE_W-1:0] xbus_be_o
    , output logic [tile_pkg::DATA_W-1:0] xbus_wdata_o
    , input logic xbus_ack_i
    , input logic xbus_resp_i
    , input logic [tile_pkg::DATA_W-1:0] xbus_rdata_i

    , output logic cpu_reset_o
    , output logic irq_req_o
    , output logic [tile_pkg::IRQ_CODE_W-1:0] irq_code_o
    , input logic irq_ack_i
);

    logic ram_req;
    logic ram_we;
    logic [tile_pkg::ADDR_W-1:0] ram_addr;
    logic [tile_pkg::BE_W-1:0] ram_be;
    logic [tile_pkg::DATA_W-1:0] ram_wdata;
    logic ram_ack;
    logic ram_resp;
    logic [tile_pkg::DATA_W-1:0] ram_rdata;

    logic sfr_req;
    logic sfr_we;
    logic [tile_pkg::ADDR_W-1:0] sfr_addr;
    logic [tile_pkg::BE_W-1:0] sfr_be;
    logic [tile_pkg::DATA_W-1:0] sfr_wdata;
    logic sfr_ack;
    logic sfr_resp;
    logic [tile_pkg::DATA_W-1:0] sfr_rdata;

    logic msi_req;
    logic [tile_pkg::IRQ_CODE_W-1:0] msi_code;

    bus_arbiter
    #(
        .XBUS_BITSEL(XBUS_BITSEL)
        , .SFR_BITSEL(SFR_BITSEL)
    ) arb (
        .clk_i(clk_i)
        , .reset_i(reset_i)

        , .host_req_i(host_req_i)
        , .host_we_i(host_we_i)
        , .host_addr_i(host_addr_i)
        , .host_be_i(host_be_i)
        , .host_wdata_i(host_wdata_i)
        , .host_ack_o(host_ack_o)
        , .host_resp_o(host_resp_o)
        , .host_rdata_o(host_rdata_o)

        , .cpu_req_i(cpu_req_i)
        , .cpu_we_i(cpu_we_i)
        , .cpu_addr_i(cpu_addr_i)
        , .cpu_be_i(cpu_be_i)
        , .cpu_wdata_i(cpu_wdata_i)
        , .cpu_ack_o(cpu_ack_o)
        , .cpu_resp_o(cpu_resp_o)
        , .cpu_rdata_o(cpu_rdata_o)

        , .ram_req_o(ram_req)
        , .ram_we_o(ram_we)
        , .ram_addr_o(ram_addr)
        , .ram_be_o(ram_be)
        , .ram_wdata_o(ram_wdata)
        , .ram_ack_i(ram_ack)
        , .ram_resp_i(ram_resp)
        , .ram_rdata_i(ram_rdata)

        , .sfr_req_o(sfr_req)
        , .sfr_we_o(sfr_we)
        , .sfr_addr_o(sfr_addr)
        , .sfr_be_o(sfr_be)
        , .sfr_wdata_o(sfr_wdata)
        , .sfr_ack_i(sfr_ack)
        , .sfr_resp_i(sfr_resp)
        , .sfr_rdata_i(sfr_rdata)

        , .xbus_req_o(xbus_req_o)
        , .xbus_we_o(xbus_we_o)
        , .xbus_addr_o(xbus_addr_o)
        , .xbus_be_o(xbus_be_o)
        , .xbus_wdata_o(xbus_wdata_o)
        , .xbus_ack_i(xbus_ack_i)
        , .xbus_resp_i(xbus_resp_i)
        , .xbus_rdata_i(xbus_rdata_i)
    );

    data_ram
    #(
        .MEM_SIZE(MEM_SIZE)
    ) ram (
        .clk_i(clk_i)
        , .reset_i(reset_i)
        , .req_i(ram_req)
        , .we_i(ram_we)
        , .addr_i(ram_addr)
        , .be_i(ram_be)
        , .wdata_i(ram_wdata)
        , .ack_o(ram_ack)
        , .resp_o(ram_resp)
        , .rdata_o(ram_rdata)
    );

    sfr_block
    #(
        .CORENUM(CORENUM)
        , .CPU_RESET_DEFAULT(CPU_RESET_DEFAULT)
    ) sfr (
        .clk_i(clk_i)
        , .reset_i(reset_i)
        , .req_i(sfr_req)
        , .we_i(sfr_we)
        , .addr_i(sfr_addr)
        , .be_i(sfr_be)
        , .wdata_i(sfr_wdata)
        , .ack_o(sfr_ack)
        , .resp_o(sfr_resp)
        , .rdata_o(sfr_rdata)
        , .cpu_reset_o(cpu_reset_o)
        , .msi_req_o(msi_req)
        , .msi_code_o(msi_code)
    );

    irq_adapter irq (
        .clk_i(clk_i)
        , .reset_i(reset_i)
        , .irq_debounced_i(irq_debounced_i)
        , .msi_req_i(msi_req)
        , .msi_code_i(msi_code)
        , .irq_req_o(irq_req_o)
        , .irq_code_o(irq_code_o)
        , .irq_ack_i(irq_ack_i)
    );

endmodule

`default_nettype wire

//--- verilog/tile_pkg.sv
`default_nettype none

package tile_pkg;

    // bus geometry
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int BE_W   = DATA_W / 8;

    // address bits steering the arbiter
    localparam int XBUS_BITSEL = 31;
    localparam int SFR_BITSEL  = 20;

    // register block byte offsets
    localparam int unsigned SFR_COREID_OFS = 32'h0;
    localparam int unsigned SFR_RESET_OFS  = 32'h4;
    localparam int unsigned SFR_MSI_OFS    = 32'h8;

    // interrupt channel towards the core
    localparam int IRQ_CODE_W = 8;
    localparam logic [IRQ_CODE_W-1:0] IRQ_EXT_CODE = 8'hFF;

endpackage

`default_nettype wire
